// File: verilog/eth_pkg.sv
// ethernet octet and crc types, frame constants, crc-32 byte update function
package eth_pkg;

    // one octet on gmii or on the internal stream
    typedef logic [7:0] eth_byte_t;

    // running crc-32 register
    typedef logic [31:0] crc32_t;

    localparam eth_byte_t ETH_PREAMBLE_BYTE = 8'h55;
    localparam eth_byte_t ETH_SFD = 8'hd5;

    // preamble octets ahead of the sfd
    localparam int ETH_PREAMBLE_LEN = 7;

    // minimum octets ahead of the fcs (64 minus the fcs)
    localparam int ETH_MIN_PAYLOAD = 60;

    // idle clocks between transmitted frames
    localparam int ETH_IFG = 12;

    // reflected ieee 802.3 polynomial and its start value
    localparam crc32_t ETH_CRC_POLY = 32'hedb88320;
    localparam crc32_t ETH_CRC_INIT = 32'hffffffff;

    // register value left after a frame and its correct fcs went through
    localparam crc32_t ETH_CRC_RESIDUE = 32'hdebb20e3;

    // advance the crc by one octet, lsb first
    function automatic crc32_t crc32_next(input crc32_t crc, input eth_byte_t data);
        crc32_t c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ ETH_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// File: verilog/gmii_rx.sv
// gmii receive framer: preamble and sfd check, fcs strip and check, stream output
`resetall
`timescale 1ns/10ps
`default_nettype none

module gmii_rx (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire eth_pkg::eth_byte_t gmii_rxd,
    input  wire logic               gmii_rx_dv,
    input  wire logic               gmii_rx_er,

    output wire eth_pkg::eth_byte_t m_axis_tdata,
    output wire logic               m_axis_tvalid,
    output wire logic               m_axis_tlast,
    output wire logic               m_axis_tuser
);

typedef enum logic [1:0] {
    IDLE,
    PREAMBLE,
    DATA,
    DROP
} state_t;

state_t state;

// four octets held back so the fcs never reaches the stream
eth_pkg::eth_byte_t dly [4];
logic [2:0] fill;

eth_pkg::eth_byte_t out_data;
logic out_valid;

eth_pkg::crc32_t crc;
logic rx_err;
logic frame_end;

// dv falls while in the payload, so the octet held in out_data is the last one
assign frame_end = (state == DATA) && !gmii_rx_dv;

assign m_axis_tdata = out_data;
assign m_axis_tvalid = out_valid || frame_end;
assign m_axis_tlast = frame_end;

// a frame with no payload octets still ends with one bad beat
assign m_axis_tuser = frame_end &&
    (!out_valid || rx_err || (crc != eth_pkg::ETH_CRC_RESIDUE));

// delay line and output register
always_ff @(posedge clk) begin
    if (state == DATA && gmii_rx_dv) begin
        dly[0] <= gmii_rxd;
        dly[1] <= dly[0];
        dly[2] <= dly[1];
        dly[3] <= dly[2];
        out_data <= dly[3];
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= IDLE;
        fill <= '0;
        out_valid <= 1'b0;
        crc <= eth_pkg::ETH_CRC_INIT;
        rx_err <= 1'b0;
    end else begin
        case (state)
            IDLE: begin
                out_valid <= 1'b0;
                if (gmii_rx_dv) begin
                    if (gmii_rxd == eth_pkg::ETH_PREAMBLE_BYTE && !gmii_rx_er) begin
                        state <= PREAMBLE;
                    end else begin
                        state <= DROP;
                    end
                end
            end
            PREAMBLE: begin
                // fresh start for the frame that follows the sfd
                fill <= '0;
                crc <= eth_pkg::ETH_CRC_INIT;
                rx_err <= 1'b0;
                if (!gmii_rx_dv) begin
                    state <= IDLE;
                end else if (gmii_rx_er) begin
                    state <= DROP;
                end else if (gmii_rxd == eth_pkg::ETH_SFD) begin
                    state <= DATA;
                end else if (gmii_rxd != eth_pkg::ETH_PREAMBLE_BYTE) begin
                    state <= DROP;
                end
            end
            DATA: begin
                if (gmii_rx_dv) begin
                    crc <= eth_pkg::crc32_next(crc, gmii_rxd);
                    if (gmii_rx_er) begin
                        rx_err <= 1'b1;
                    end
                    if (fill == 3'd4) begin
                        out_valid <= 1'b1;
                    end else begin
                        fill <= fill + 3'd1;
                    end
                end else begin
                    out_valid <= 1'b0;
                    state <= IDLE;
                end
            end
            DROP: begin
                // wait out the rest of a malformed frame
                if (!gmii_rx_dv) begin
                    state <= IDLE;
                end
            end
            default: begin
                state <= IDLE;
            end
        endcase
    end
end

endmodule

`resetall

// File: verilog/gmii_tx.sv
// gmii transmit framer: preamble, sfd, zero padding, fcs and inter-frame gap
`resetall
`timescale 1ns/10ps
`default_nettype none

module gmii_tx (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire eth_pkg::eth_byte_t s_axis_tdata,
    input  wire logic               s_axis_tvalid,
    output wire logic               s_axis_tready,
    input  wire logic               s_axis_tlast,
    input  wire logic               s_axis_tuser,

    output      eth_pkg::eth_byte_t gmii_txd,
    output      logic               gmii_tx_en,
    output      logic               gmii_tx_er
);

typedef enum logic [2:0] {
    IDLE,
    PREAMBLE,
    PAYLOAD,
    PAD,
    FCS,
    IFG
} state_t;

state_t state;

// octet counter, saturates once the minimum payload is reached
logic [7:0] cnt;
eth_pkg::crc32_t crc;

assign s_axis_tready = (state == PAYLOAD);

always_ff @(posedge clk) begin
    if (rst) begin
        state <= IDLE;
        cnt <= '0;
        crc <= eth_pkg::ETH_CRC_INIT;
        gmii_txd <= '0;
        gmii_tx_en <= 1'b0;
        gmii_tx_er <= 1'b0;
    end else begin
        gmii_tx_er <= 1'b0;
        case (state)
            IDLE: begin
                gmii_txd <= '0;
                gmii_tx_en <= 1'b0;
                crc <= eth_pkg::ETH_CRC_INIT;
                cnt <= '0;
                if (s_axis_tvalid) begin
                    gmii_txd <= eth_pkg::ETH_PREAMBLE_BYTE;
                    gmii_tx_en <= 1'b1;
                    cnt <= 8'd1;
                    state <= PREAMBLE;
                end
            end
            PREAMBLE: begin
                if (cnt < eth_pkg::ETH_PREAMBLE_LEN) begin
                    gmii_txd <= eth_pkg::ETH_PREAMBLE_BYTE;
                    cnt <= cnt + 8'd1;
                end else begin
                    gmii_txd <= eth_pkg::ETH_SFD;
                    cnt <= '0;
                    state <= PAYLOAD;
                end
            end
            PAYLOAD: begin
                if (s_axis_tvalid) begin
                    gmii_txd <= s_axis_tdata;
                    crc <= eth_pkg::crc32_next(crc, s_axis_tdata);
                    if (cnt < eth_pkg::ETH_MIN_PAYLOAD) begin
                        cnt <= cnt + 8'd1;
                    end
                    if (s_axis_tlast) begin
                        // poison the frame on the wire if upstream flagged it
                        gmii_tx_er <= s_axis_tuser;
                        if (cnt + 1 < eth_pkg::ETH_MIN_PAYLOAD) begin
                            state <= PAD;
                        end else begin
                            cnt <= '0;
                            state <= FCS;
                        end
                    end
                end else begin
                    // source ran dry mid-frame
                    gmii_txd <= '0;
                    gmii_tx_er <= 1'b1;
                end
            end
            PAD: begin
                gmii_txd <= '0;
                crc <= eth_pkg::crc32_next(crc, 8'h00);
                cnt <= cnt + 8'd1;
                if (cnt + 1 >= eth_pkg::ETH_MIN_PAYLOAD) begin
                    cnt <= '0;
                    state <= FCS;
                end
            end
            FCS: begin
                // complemented crc, low octet first
                gmii_txd <= ~crc[7:0];
                crc <= crc >> 8;
                cnt <= cnt + 8'd1;
                if (cnt == 8'd3) begin
                    cnt <= '0;
                    state <= IFG;
                end
            end
            IFG: begin
                gmii_txd <= '0;
                gmii_tx_en <= 1'b0;
                cnt <= cnt + 8'd1;
                if (cnt >= eth_pkg::ETH_IFG - 1) begin
                    state <= IDLE;
                end
            end
            default: begin
                state <= IDLE;
            end
        endcase
    end
end

endmodule

`resetall

// File: verilog/frame_fifo.sv
// store-and-forward frame fifo with commit on good frames and drop on bad or overflow
`resetall
`timescale 1ns/10ps
`default_nettype none

module frame_fifo #(
    parameter int FIFO_DEPTH = 2048
) (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire eth_pkg::eth_byte_t s_axis_tdata,
    input  wire logic               s_axis_tvalid,
    input  wire logic               s_axis_tlast,
    input  wire logic               s_axis_tuser,

    output wire eth_pkg::eth_byte_t m_axis_tdata,
    output wire logic               m_axis_tvalid,
    input  wire logic               m_axis_tready,
    output wire logic               m_axis_tlast,
    output wire logic               m_axis_tuser,

    output      logic               good_frame,
    output      logic               bad_frame
);

localparam int ADDR_W = $clog2(FIFO_DEPTH);

// each entry is {tlast, tdata}
logic [8:0] mem [FIFO_DEPTH];

// one extra bit on each pointer to tell full from empty
logic [ADDR_W:0] wr_ptr;
logic [ADDR_W:0] wr_ptr_commit;
logic [ADDR_W:0] rd_ptr;

logic drop_frame;
logic full;
logic empty;

assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
    (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
assign empty = (rd_ptr == wr_ptr_commit);

// fall-through read, only whole good frames are ever visible here
assign {m_axis_tlast, m_axis_tdata} = mem[rd_ptr[ADDR_W-1:0]];
assign m_axis_tvalid = !empty;
assign m_axis_tuser = 1'b0;

always_ff @(posedge clk) begin
    if (s_axis_tvalid && !drop_frame && !full) begin
        mem[wr_ptr[ADDR_W-1:0]] <= {s_axis_tlast, s_axis_tdata};
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr <= '0;
        wr_ptr_commit <= '0;
        rd_ptr <= '0;
        drop_frame <= 1'b0;
        good_frame <= 1'b0;
        bad_frame <= 1'b0;
    end else begin
        good_frame <= 1'b0;
        bad_frame <= 1'b0;

        if (s_axis_tvalid) begin
            if (drop_frame) begin
                // skip the tail of a frame that already overflowed
                if (s_axis_tlast) begin
                    drop_frame <= 1'b0;
                    bad_frame <= 1'b1;
                end
            end else if (full) begin
                wr_ptr <= wr_ptr_commit;
                if (s_axis_tlast) begin
                    bad_frame <= 1'b1;
                end else begin
                    drop_frame <= 1'b1;
                end
            end else if (s_axis_tlast) begin
                if (s_axis_tuser) begin
                    wr_ptr <= wr_ptr_commit;
                    bad_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    wr_ptr_commit <= wr_ptr + 1'b1;
                    good_frame <= 1'b1;
                end
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end

        if (m_axis_tvalid && m_axis_tready) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end
end

endmodule

`resetall

// File: verilog/eth_mac_1g_fifo.sv
// 1g mac: gmii receive framer into a frame fifo, stream into gmii transmit framer
`resetall
`timescale 1ns/10ps
`default_nettype none

module eth_mac_1g_fifo #(
    parameter int FIFO_DEPTH = 2048
) (
    input  wire logic               clk,
    input  wire logic               rst,

    // gmii
    input  wire eth_pkg::eth_byte_t gmii_rxd,
    input  wire logic               gmii_rx_dv,
    input  wire logic               gmii_rx_er,
    output wire eth_pkg::eth_byte_t gmii_txd,
    output wire logic               gmii_tx_en,
    output wire logic               gmii_tx_er,

    // transmit stream
    input  wire eth_pkg::eth_byte_t tx_axis_tdata,
    input  wire logic               tx_axis_tvalid,
    output wire logic               tx_axis_tready,
    input  wire logic               tx_axis_tlast,
    input  wire logic               tx_axis_tuser,

    // receive stream
    output wire eth_pkg::eth_byte_t rx_axis_tdata,
    output wire logic               rx_axis_tvalid,
    input  wire logic               rx_axis_tready,
    output wire logic               rx_axis_tlast,
    output wire logic               rx_axis_tuser,

    output wire logic               rx_good_frame,
    output wire logic               rx_bad_frame
);

// framer to fifo, no back-pressure
eth_pkg::eth_byte_t rx_mac_tdata;
logic rx_mac_tvalid;
logic rx_mac_tlast;
logic rx_mac_tuser;

gmii_rx rx_inst (
    .clk(clk),
    .rst(rst),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .m_axis_tdata(rx_mac_tdata),
    .m_axis_tvalid(rx_mac_tvalid),
    .m_axis_tlast(rx_mac_tlast),
    .m_axis_tuser(rx_mac_tuser)
);

frame_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
) rx_fifo_inst (
    .clk(clk),
    .rst(rst),
    .s_axis_tdata(rx_mac_tdata),
    .s_axis_tvalid(rx_mac_tvalid),
    .s_axis_tlast(rx_mac_tlast),
    .s_axis_tuser(rx_mac_tuser),
    .m_axis_tdata(rx_axis_tdata),
    .m_axis_tvalid(rx_axis_tvalid),
    .m_axis_tready(rx_axis_tready),
    .m_axis_tlast(rx_axis_tlast),
    .m_axis_tuser(rx_axis_tuser),
    .good_frame(rx_good_frame),
    .bad_frame(rx_bad_frame)
);

gmii_tx tx_inst (
    .clk(clk),
    .rst(rst),
    .s_axis_tdata(tx_axis_tdata),
    .s_axis_tvalid(tx_axis_tvalid),
    .s_axis_tready(tx_axis_tready),
    .s_axis_tlast(tx_axis_tlast),
    .s_axis_tuser(tx_axis_tuser),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_tx_er(gmii_tx_er)
);

endmodule

`resetall

// File: verilog/fpga_core.sv
// top level: single gmii port looped back through the mac, frame status leds
`resetall
`timescale 1ns/10ps
`default_nettype none

module fpga_core #(
    // frame fifo size in octets, power of two
    parameter int FIFO_DEPTH = 2048
) (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire eth_pkg::eth_byte_t gmii_rxd,
    input  wire logic               gmii_rx_dv,
    input  wire logic               gmii_rx_er,
    output wire eth_pkg::eth_byte_t gmii_txd,
    output wire logic               gmii_tx_en,
    output wire logic               gmii_tx_er,

    output wire logic [1:0]         led
);

// receive stream fed straight back into transmit
eth_pkg::eth_byte_t axis_eth_tdata;
logic axis_eth_tvalid;
logic axis_eth_tready;
logic axis_eth_tlast;
logic axis_eth_tuser;

logic rx_good_frame;
logic rx_bad_frame;

logic led_good;
logic led_bad;

eth_mac_1g_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
) eth_mac_inst (
    .clk(clk),
    .rst(rst),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_tx_er(gmii_tx_er),
    .tx_axis_tdata(axis_eth_tdata),
    .tx_axis_tvalid(axis_eth_tvalid),
    .tx_axis_tready(axis_eth_tready),
    .tx_axis_tlast(axis_eth_tlast),
    .tx_axis_tuser(axis_eth_tuser),
    .rx_axis_tdata(axis_eth_tdata),
    .rx_axis_tvalid(axis_eth_tvalid),
    .rx_axis_tready(axis_eth_tready),
    .rx_axis_tlast(axis_eth_tlast),
    .rx_axis_tuser(axis_eth_tuser),
    .rx_good_frame(rx_good_frame),
    .rx_bad_frame(rx_bad_frame)
);

// each led flips once per frame of its kind
always_ff @(posedge clk) begin
    if (rst) begin
        led_good <= 1'b0;
        led_bad <= 1'b0;
    end else begin
        if (rx_good_frame) begin
            led_good <= !led_good;
        end
        if (rx_bad_frame) begin
            led_bad <= !led_bad;
        end
    end
end

assign led = {led_bad, led_good};

endmodule

`resetall

// File: tb/tb_fpga_core.sv
// testbench for fpga_core: gmii frame builder, reference crc, compare tasks, directed tests
`timescale 1ns/10ps

module tb_fpga_core;

localparam int WAIT_LIMIT = 2000;
localparam int CAP_MAX = 1024;
localparam int SILENCE = 200;

logic clk;
logic rst;
eth_pkg::eth_byte_t gmii_rxd;
logic gmii_rx_dv;
logic gmii_rx_er;
eth_pkg::eth_byte_t gmii_txd;
logic gmii_tx_en;
logic gmii_tx_er;
logic [1:0] led;

integer seed;

// payload slots and the captured transmit frame
eth_pkg::eth_byte_t pay [3][512];
int pay_len [3];
eth_pkg::eth_byte_t cap [CAP_MAX];
int cap_len;
int idle_cycles;
logic [1:0] exp_led;

fpga_core #(
    .FIFO_DEPTH(256)
) dut0 (
    .clk(clk),
    .rst(rst),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_tx_er(gmii_tx_er),
    .led(led)
);

always #2 clk = ~clk;

task automatic mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1);
endtask

task automatic give_up(input string msg);
    $display("timeout at %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1);
endtask

task automatic check_byte(input string msg, input eth_pkg::eth_byte_t got,
                          input eth_pkg::eth_byte_t want);
    if (got !== want) begin
        mismatch($sformatf("%s: got %02h expected %02h", msg, got, want));
    end
endtask

task automatic check_crc(input string msg, input eth_pkg::crc32_t got,
                         input eth_pkg::crc32_t want);
    if (got !== want) begin
        mismatch($sformatf("%s: got %08h expected %08h", msg, got, want));
    end
endtask

task automatic check_bit(input string msg, input logic got, input logic want);
    if (got !== want) begin
        mismatch($sformatf("%s: got %b expected %b", msg, got, want));
    end
endtask

task automatic check_count(input string msg, input int got, input int want);
    if (got != want) begin
        mismatch($sformatf("%s: got %0d expected %0d", msg, got, want));
    end
endtask

// bitwise ieee crc-32 over a payload slot, zero filled up to count octets
function automatic eth_pkg::crc32_t fcs_of(input int slot, input int count);
    eth_pkg::crc32_t r;
    eth_pkg::eth_byte_t b;
    logic fb;
    r = 32'hffffffff;
    for (int i = 0; i < count; i++) begin
        b = (i < pay_len[slot]) ? pay[slot][i] : 8'h00;
        for (int k = 0; k < 8; k++) begin
            fb = r[0] ^ b[k];
            r = {1'b0, r[31:1]};
            if (fb) begin
                r = r ^ 32'hedb88320;
            end
        end
    end
    return ~r;
endfunction

task automatic make_payload(input int slot, input int len);
    logic [31:0] rnd;
    pay_len[slot] = len;
    for (int i = 0; i < len; i++) begin
        rnd = $random(seed);
        pay[slot][i] = rnd[7:0];
    end
endtask

task automatic drive_octet(input eth_pkg::eth_byte_t data, input logic er);
    @(negedge clk);
    gmii_rxd = data;
    gmii_rx_dv = 1'b1;
    gmii_rx_er = er;
endtask

// preamble, sfd, payload, fcs low octet first; er_at below zero means no error
task automatic send_frame(input int slot, input logic bad_fcs, input int er_at);
    eth_pkg::crc32_t fcs;
    fcs = fcs_of(slot, pay_len[slot]);
    if (bad_fcs) begin
        fcs = fcs ^ 32'h00000100;
    end
    for (int i = 0; i < eth_pkg::ETH_PREAMBLE_LEN; i++) begin
        drive_octet(eth_pkg::ETH_PREAMBLE_BYTE, 1'b0);
    end
    drive_octet(eth_pkg::ETH_SFD, 1'b0);
    for (int i = 0; i < pay_len[slot]; i++) begin
        drive_octet(pay[slot][i], i == er_at);
    end
    for (int i = 0; i < 4; i++) begin
        drive_octet(fcs[8*i +: 8], 1'b0);
    end
    @(negedge clk);
    gmii_rxd = '0;
    gmii_rx_dv = 1'b0;
    gmii_rx_er = 1'b0;
endtask

// waits for gmii_tx_en, then captures octets until it drops
task automatic collect;
    int waited;
    waited = 0;
    while (!gmii_tx_en) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
            give_up("no frame appeared on gmii_tx_en");
        end
        @(negedge clk);
    end
    idle_cycles = waited;
    cap_len = 0;
    while (gmii_tx_en) begin
        check_bit("gmii_tx_er inside frame", gmii_tx_er, 1'b0);
        cap[cap_len] = gmii_txd;
        cap_len++;
        if (cap_len >= CAP_MAX) begin
            give_up("transmitted frame never ended");
        end
        @(negedge clk);
    end
endtask

task automatic verify_frame(input int slot);
    int body;
    eth_pkg::eth_byte_t want;
    eth_pkg::crc32_t got_fcs;
    body = (pay_len[slot] < eth_pkg::ETH_MIN_PAYLOAD) ? eth_pkg::ETH_MIN_PAYLOAD : pay_len[slot];
    check_count("transmitted length", cap_len, 8 + body + 4);
    for (int i = 0; i < eth_pkg::ETH_PREAMBLE_LEN; i++) begin
        check_byte($sformatf("preamble octet %0d", i), cap[i], eth_pkg::ETH_PREAMBLE_BYTE);
    end
    check_byte("sfd", cap[7], eth_pkg::ETH_SFD);
    for (int i = 0; i < body; i++) begin
        want = (i < pay_len[slot]) ? pay[slot][i] : 8'h00;
        check_byte($sformatf("payload octet %0d", i), cap[8 + i], want);
    end
    got_fcs = {cap[8 + body + 3], cap[8 + body + 2], cap[8 + body + 1], cap[8 + body]};
    check_crc("fcs", got_fcs, fcs_of(slot, body));
endtask

task automatic expect_silence(input int cycles);
    for (int i = 0; i < cycles; i++) begin
        @(negedge clk);
        check_bit("gmii_tx_en for a dropped frame", gmii_tx_en, 1'b0);
    end
endtask

task automatic good_frame_loops;
    make_payload(0, 60);
    send_frame(0, 1'b0, -1);
    collect();
    verify_frame(0);
    exp_led[0] = !exp_led[0];
    check_bit("led[0] after good frame", led[0], exp_led[0]);
endtask

task automatic bad_fcs_drops;
    make_payload(0, 60);
    send_frame(0, 1'b1, -1);
    expect_silence(SILENCE);
    exp_led[1] = !exp_led[1];
    check_bit("led[1] after bad fcs", led[1], exp_led[1]);
    check_bit("led[0] after bad fcs", led[0], exp_led[0]);
endtask

task automatic short_frame_pads;
    make_payload(0, 20);
    send_frame(0, 1'b0, -1);
    collect();
    verify_frame(0);
    exp_led[0] = !exp_led[0];
    check_bit("led[0] after short frame", led[0], exp_led[0]);
endtask

task automatic rx_error_drops;
    make_payload(0, 80);
    send_frame(0, 1'b0, 30);
    expect_silence(SILENCE);
    exp_led[1] = !exp_led[1];
    check_bit("led[1] after rx error", led[1], exp_led[1]);
endtask

task automatic frames_stay_in_order;
    make_payload(0, 60);
    make_payload(1, 100);
    make_payload(2, 75);
    fork
        begin
            send_frame(0, 1'b0, -1);
            send_frame(1, 1'b0, -1);
            send_frame(2, 1'b0, -1);
        end
        begin
            collect();
            verify_frame(0);
            for (int f = 1; f < 3; f++) begin
                collect();
                if (idle_cycles < eth_pkg::ETH_IFG) begin
                    mismatch($sformatf("gap before frame %0d is %0d clocks", f, idle_cycles));
                end
                verify_frame(f);
            end
        end
    join
    // three toggles leave the led inverted
    exp_led[0] = !exp_led[0];
    check_bit("led[0] after three frames", led[0], exp_led[0]);
endtask

task automatic overflow_drops;
    make_payload(0, 300);
    make_payload(1, 70);
    send_frame(0, 1'b0, -1);
    send_frame(1, 1'b0, -1);
    collect();
    verify_frame(1);
    exp_led[1] = !exp_led[1];
    exp_led[0] = !exp_led[0];
    check_bit("led[1] after overflow", led[1], exp_led[1]);
    check_bit("led[0] after overflow", led[0], exp_led[0]);
endtask

initial begin
    seed = 93916;
    clk = 1'b0;
    rst = 1'b1;
    gmii_rxd = '0;
    gmii_rx_dv = 1'b0;
    gmii_rx_er = 1'b0;
    exp_led = 2'b00;
    cap_len = 0;
    idle_cycles = 0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    check_bit("gmii_tx_en after reset", gmii_tx_en, 1'b0);
    check_bit("gmii_tx_er after reset", gmii_tx_er, 1'b0);
    check_bit("led[0] after reset", led[0], 1'b0);
    check_bit("led[1] after reset", led[1], 1'b0);

    good_frame_loops();
    bad_fcs_drops();
    short_frame_pads();
    rx_error_drops();
    frames_stay_in_order();
    overflow_drops();

    $display("All tests passed");
    $finish;
end

endmodule

// File: list.f
verilog/eth_pkg.sv
verilog/gmii_rx.sv
verilog/gmii_tx.sv
verilog/frame_fifo.sv
verilog/eth_mac_1g_fifo.sv
verilog/fpga_core.sv
tb/tb_fpga_core.sv
